//--- design/rv_core_settings.svh
// build-time settings for the rv_core RISC-V core
// include before the package and in any module that reads these values

`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// architectural register file
`define RV_NREGS 32
`define RV_REG_IDX_W 5

// arbiter tie-break, 1 lets the execute unit win
`define RV_EXEC_PRIORITY 1

`endif

//--- design/rv_core_pkg.sv
// shared types of the rv_core design
// modules take it with a wildcard import in their header

`default_nettype none

`include "rv_core_settings.svh"

package rv_core_pkg;

  // ------------------------------
  // vector types
  // ------------------------------
  typedef logic [`RV_XLEN-1:0]      word_t;
  typedef logic [`RV_XLEN-1:0]      addr_t;
  typedef logic [31:0]              instr_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [31:0]              count_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ------------------------------
  // state machines
  // ------------------------------
  typedef enum logic [1:0] {EX_IDLE, EX_MEM_WAIT, EX_HALTED} exec_state_e;

  typedef enum logic [2:0] {
    ARB_IDLE, ARB_READ_ADDR, ARB_READ_DATA, ARB_WRITE, ARB_WRITE_RESP
  } arb_state_e;

endpackage

`default_nettype wire

//--- design/core_ifs.sv
// internal buses of the core
// mem_bus_if links one requester to the arbiter, fetch_if hands
// fetched instructions from the fetch unit to the execute unit

`default_nettype none

interface mem_bus_if import rv_core_pkg::*; ();
  // request side
  logic  req_valid;
  logic  req_ready;
  logic  req_we;
  addr_t req_addr;
  word_t req_wdata;
  // one response pulse per request
  logic  rsp_valid;
  word_t rsp_rdata;

  modport requester (
    output req_valid, req_we, req_addr, req_wdata,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport arbiter (
    input  req_valid, req_we, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_rdata
  );
endinterface

interface fetch_if import rv_core_pkg::*; ();
  logic   instr_valid;
  logic   instr_ready;
  instr_t instr;
  addr_t  pc;
  // execute unit stopped, no more fetches
  logic   halt;

  modport fetcher  (output instr_valid, instr, pc, input instr_ready, halt);
  modport executor (input instr_valid, instr, pc, output instr_ready, halt);
endinterface

`default_nettype wire

//--- design/fetch_unit.sv
// instruction fetch: reads words from the boot address onward and
// keeps one fetched instruction ready for the execute unit

`default_nettype none

module fetch_unit import rv_core_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  addr_t        boot_addr_i,
  mem_bus_if.requester bus,
  fetch_if.fetcher     fetch
);

  addr_t  pc_q;
  logic   pending_q;
  logic   buf_valid_q;
  instr_t buf_instr_q;
  addr_t  buf_pc_q;
  logic   hand_over;
  logic   issue;

  assign hand_over = fetch.instr_valid && fetch.instr_ready;

  // next fetch once the buffer is free or being freed
  assign bus.req_valid = !pending_q && (!buf_valid_q || hand_over) && !fetch.halt;
  assign bus.req_we    = 1'b0;
  assign bus.req_addr  = pc_q;
  assign bus.req_wdata = '0;
  assign issue         = bus.req_valid && bus.req_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q        <= boot_addr_i;
      pending_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (issue) begin
        pc_q      <= pc_q + 32'd4;
        pending_q <= 1'b1;
      end else if (bus.rsp_valid) begin
        pending_q <= 1'b0;
      end
      if (bus.rsp_valid) begin
        buf_valid_q <= 1'b1;
      end else if (hand_over) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // pc already advanced past the word in flight
  always_ff @(posedge clk_i) begin
    if (bus.rsp_valid) begin
      buf_instr_q <= bus.rsp_rdata;
      buf_pc_q    <= pc_q - 32'd4;
    end
  end

  assign fetch.instr_valid = buf_valid_q;
  assign fetch.instr       = buf_instr_q;
  assign fetch.pc          = buf_pc_q;

  // boot address must be word aligned too
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- design/exec_unit.sv
// decode, execute and retire, one instruction at a time
// loads and stores go out on the shared memory bus, ECALL stops the core

`default_nettype none

`include "rv_core_settings.svh"

module exec_unit import rv_core_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  fetch_if.executor    fetch,
  mem_bus_if.requester bus,
  output count_t       instret_o,
  output logic         halted_o
);

  exec_state_e state_q;
  instr_t      cur_q;
  addr_t       cur_pc_q;
  logic        cur_valid_q;
  count_t      instret_q;
  word_t       rf_q [1:`RV_NREGS-1];

  opcode_e     opc;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  reg_idx_t    rd;
  word_t       rs1_val;
  word_t       rs2_val;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_u;
  word_t       alu_res;
  logic        alu_we;
  logic        is_load;
  logic        is_store;
  logic        is_mem;
  logic        is_ecall;
  logic        accept;
  logic        retire;
  logic        rf_we;
  word_t       rf_wdata;

  // ------------------------------
  // decode
  // ------------------------------
  assign opc    = opcode_e'(cur_q[6:0]);
  assign funct3 = cur_q[14:12];
  assign funct7 = cur_q[31:25];
  assign rs1    = cur_q[19:15];
  assign rs2    = cur_q[24:20];
  assign rd     = cur_q[11:7];

  assign imm_i = {{20{cur_q[31]}}, cur_q[31:20]};
  assign imm_s = {{20{cur_q[31]}}, cur_q[31:25], cur_q[11:7]};
  assign imm_u = {cur_q[31:12], 12'b0};

  // x0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];

  // only word accesses, other widths retire as no-ops
  assign is_load  = (opc == OPC_LOAD) && (funct3 == 3'b010);
  assign is_store = (opc == OPC_STORE) && (funct3 == 3'b010);
  assign is_mem   = is_load || is_store;
  assign is_ecall = (opc == OPC_SYSTEM) && (cur_q[31:7] == '0);

  always_comb begin
    alu_res = '0;
    alu_we  = 1'b0;
    case (opc)
      OPC_LUI: begin
        alu_res = imm_u;
        alu_we  = 1'b1;
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          alu_res = rs1_val + imm_i;
          alu_we  = 1'b1;
        end
      end
      OPC_OP: begin
        alu_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_res = rs1_val + rs2_val;
          {7'h20, 3'b000}: alu_res = rs1_val - rs2_val;
          {7'h00, 3'b100}: alu_res = rs1_val ^ rs2_val;
          {7'h00, 3'b110}: alu_res = rs1_val | rs2_val;
          {7'h00, 3'b111}: alu_res = rs1_val & rs2_val;
          default:         alu_we  = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  // ------------------------------
  // handshakes and retirement
  // ------------------------------
  assign fetch.instr_ready = (state_q == EX_IDLE) && !(cur_valid_q && (is_mem || is_ecall));
  assign accept            = fetch.instr_valid && fetch.instr_ready;

  assign bus.req_valid = (state_q == EX_IDLE) && cur_valid_q && is_mem;
  assign bus.req_we    = is_store;
  assign bus.req_addr  = rs1_val + (is_store ? imm_s : imm_i);
  assign bus.req_wdata = rs2_val;

  assign retire = cur_valid_q && (((state_q == EX_IDLE) && !is_mem) ||
                                  ((state_q == EX_MEM_WAIT) && bus.rsp_valid));

  assign rf_we    = retire && (rd != '0) && (alu_we || is_load);
  assign rf_wdata = is_load ? bus.rsp_rdata : alu_res;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= EX_IDLE;
      cur_valid_q <= 1'b0;
      instret_q   <= '0;
    end else begin
      if (retire) begin
        instret_q <= instret_q + 32'd1;
      end
      case (state_q)
        EX_IDLE: begin
          if (cur_valid_q && is_ecall) begin
            state_q <= EX_HALTED;
          end else if (bus.req_valid && bus.req_ready) begin
            state_q <= EX_MEM_WAIT;
          end
        end
        EX_MEM_WAIT: begin
          if (bus.rsp_valid) begin
            state_q <= EX_IDLE;
          end
        end
        default: ;
      endcase
      if (accept) begin
        cur_valid_q <= 1'b1;
      end else if (retire) begin
        cur_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_q    <= fetch.instr;
      cur_pc_q <= fetch.pc;
    end
    if (rf_we) begin
      rf_q[rd] <= rf_wdata;
    end
  end

  assign fetch.halt = (state_q == EX_HALTED);
  assign halted_o   = (state_q == EX_HALTED);
  assign instret_o  = instret_q;

  // responses only arrive for the open load or store, never once halted
  a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.rsp_valid |-> state_q == EX_MEM_WAIT);

  // back-to-back instructions arrive in program order
  a_pc_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && cur_valid_q |-> fetch.pc == cur_pc_q + 32'd4);

endmodule

`default_nettype wire

//--- design/axi_lite_arbiter.sv
// shares one AXI4-Lite master port between fetch and execute
// serves one word transaction to completion, then answers the requester

`default_nettype none

`include "rv_core_settings.svh"

module axi_lite_arbiter import rv_core_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  mem_bus_if.arbiter              fetch_bus,
  mem_bus_if.arbiter              exec_bus,
  // read channels
  output addr_t                   axi_araddr_o,
  output logic                    axi_arvalid_o,
  input  logic                    axi_arready_i,
  input  word_t                   axi_rdata_i,
  input  logic                    axi_rvalid_i,
  output logic                    axi_rready_o,
  // write channels
  output addr_t                   axi_awaddr_o,
  output logic                    axi_awvalid_o,
  input  logic                    axi_awready_i,
  output word_t                   axi_wdata_o,
  output logic [`RV_XLEN/8-1:0]   axi_wstrb_o,
  output logic                    axi_wvalid_o,
  input  logic                    axi_wready_i,
  input  logic                    axi_bvalid_i,
  output logic                    axi_bready_o
);

  arb_state_e state_q;
  logic       grant_exec_q;
  logic       aw_done_q;
  logic       w_done_q;
  addr_t      addr_q;
  word_t      wdata_q;

  logic       exec_first;
  logic       pick_exec;
  logic       req_fire;
  logic       sel_we;
  addr_t      sel_addr;
  word_t      sel_wdata;
  logic       aw_ok;
  logic       w_ok;
  logic       done;

  // ------------------------------
  // grant
  // ------------------------------
  assign exec_first = (`RV_EXEC_PRIORITY != 0);
  assign pick_exec  = exec_bus.req_valid && (exec_first || !fetch_bus.req_valid);
  assign req_fire   = (state_q == ARB_IDLE) && (exec_bus.req_valid || fetch_bus.req_valid);

  assign exec_bus.req_ready  = (state_q == ARB_IDLE) && pick_exec;
  assign fetch_bus.req_ready = (state_q == ARB_IDLE) && !pick_exec;

  assign sel_we    = pick_exec ? exec_bus.req_we    : fetch_bus.req_we;
  assign sel_addr  = pick_exec ? exec_bus.req_addr  : fetch_bus.req_addr;
  assign sel_wdata = pick_exec ? exec_bus.req_wdata : fetch_bus.req_wdata;

  // ------------------------------
  // AXI4-Lite sequencing
  // ------------------------------
  assign axi_araddr_o  = addr_q;
  assign axi_arvalid_o = (state_q == ARB_READ_ADDR);
  assign axi_rready_o  = (state_q == ARB_READ_DATA);
  assign axi_awaddr_o  = addr_q;
  assign axi_awvalid_o = (state_q == ARB_WRITE) && !aw_done_q;
  assign axi_wdata_o   = wdata_q;
  assign axi_wstrb_o   = '1;
  assign axi_wvalid_o  = (state_q == ARB_WRITE) && !w_done_q;
  assign axi_bready_o  = (state_q == ARB_WRITE_RESP);

  // AW and W may complete in either order
  assign aw_ok = aw_done_q || (axi_awvalid_o && axi_awready_i);
  assign w_ok  = w_done_q || (axi_wvalid_o && axi_wready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ARB_IDLE;
      grant_exec_q <= 1'b0;
      aw_done_q    <= 1'b0;
      w_done_q     <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (req_fire) begin
            grant_exec_q <= pick_exec;
            state_q      <= sel_we ? ARB_WRITE : ARB_READ_ADDR;
          end
        end
        ARB_READ_ADDR: if (axi_arready_i) state_q <= ARB_READ_DATA;
        ARB_READ_DATA: if (axi_rvalid_i) state_q <= ARB_IDLE;
        ARB_WRITE: begin
          if (aw_ok && w_ok) begin
            state_q   <= ARB_WRITE_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_ok;
            w_done_q  <= w_ok;
          end
        end
        ARB_WRITE_RESP: if (axi_bvalid_i) state_q <= ARB_IDLE;
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      addr_q  <= sel_addr;
      wdata_q <= sel_wdata;
    end
  end

  // response straight from R or B, to the granted side only
  assign done = ((state_q == ARB_READ_DATA) && axi_rvalid_i) ||
                ((state_q == ARB_WRITE_RESP) && axi_bvalid_i);

  assign exec_bus.rsp_valid  = done && grant_exec_q;
  assign fetch_bus.rsp_valid = done && !grant_exec_q;
  assign exec_bus.rsp_rdata  = axi_rdata_i;
  assign fetch_bus.rsp_rdata = axi_rdata_i;

  // the granted side sends nothing new until its response
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != ARB_IDLE |-> !(grant_exec_q ? exec_bus.req_valid : fetch_bus.req_valid));

  // read data only while a read is open
  a_r_in_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_rvalid_i |-> state_q == ARB_READ_DATA);

endmodule

`default_nettype wire

//--- design/rv_core.sv
// top level of the rv_core RISC-V integer core
// fetch and execute share one AXI4-Lite master port through the arbiter

`default_nettype none

`include "rv_core_settings.svh"

module rv_core import rv_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addr_t                 boot_addr_i,
  // AXI4-Lite master
  output addr_t                 axi_araddr_o,
  output logic                  axi_arvalid_o,
  input  logic                  axi_arready_i,
  input  word_t                 axi_rdata_i,
  input  logic                  axi_rvalid_i,
  output logic                  axi_rready_o,
  output addr_t                 axi_awaddr_o,
  output logic                  axi_awvalid_o,
  input  logic                  axi_awready_i,
  output word_t                 axi_wdata_o,
  output logic [`RV_XLEN/8-1:0] axi_wstrb_o,
  output logic                  axi_wvalid_o,
  input  logic                  axi_wready_i,
  input  logic                  axi_bvalid_i,
  output logic                  axi_bready_o,
  // status
  output count_t                instret_o,
  output logic                  halted_o
);

  mem_bus_if fetch_bus ();
  mem_bus_if exec_bus ();
  fetch_if   fetch_chan ();

  // ------------------------------
  // frontend
  // ------------------------------
  fetch_unit i_fetch_unit (
    .clk_i       ( clk_i                ),
    .rst_ni      ( rst_ni               ),
    .boot_addr_i ( boot_addr_i          ),
    .bus         ( fetch_bus.requester  ),
    .fetch       ( fetch_chan.fetcher   )
  );

  // ------------------------------
  // execute and retire
  // ------------------------------
  exec_unit i_exec_unit (
    .clk_i     ( clk_i               ),
    .rst_ni    ( rst_ni              ),
    .fetch     ( fetch_chan.executor ),
    .bus       ( exec_bus.requester  ),
    .instret_o ( instret_o           ),
    .halted_o  ( halted_o            )
  );

  // ------------------------------
  // shared memory port
  // ------------------------------
  axi_lite_arbiter i_axi_lite_arbiter (
    .clk_i, .rst_ni,
    .fetch_bus     ( fetch_bus.arbiter ),
    .exec_bus      ( exec_bus.arbiter  ),
    .axi_araddr_o, .axi_arvalid_o, .axi_arready_i,
    .axi_rdata_i, .axi_rvalid_i, .axi_rready_o,
    .axi_awaddr_o, .axi_awvalid_o, .axi_awready_i,
    .axi_wdata_o, .axi_wstrb_o, .axi_wvalid_o, .axi_wready_i,
    .axi_bvalid_i, .axi_bready_o
  );

endmodule

`default_nettype wire

//--- tb/axi_lite_mem.sv
// AXI4-Lite slave memory for the rv_core testbench
// each ready and valid follows a random 0 to 3 cycle stall
// read addresses and write transfers are queued for the checker

`default_nettype none

`include "rv_core_settings.svh"

module axi_lite_mem import rv_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addr_t                 araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output word_t                 rdata_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  addr_t                 awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  word_t                 wdata_i,
  input  logic [`RV_XLEN/8-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic                  bvalid_o,
  input  logic                  bready_i
);

  word_t                 mem [0:4095];
  addr_t                 rd_addr_q [$];
  addr_t                 wr_addr_q [$];
  word_t                 wr_data_q [$];
  logic [`RV_XLEN/8-1:0] wr_strb_q [$];
  int                    seed = 1;

  function automatic int stall_cycles();
    return $unsigned($random(seed)) % 4;
  endfunction

  // starts and ends one time unit after a clock edge
  task automatic random_stall();
    int n;
    n = stall_cycles();
    repeat (n) @(posedge clk_i);
    if (n > 0) #1;
  endtask

  // ------------------------------
  // read side, AR then R
  // ------------------------------
  initial begin
    addr_t a;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && arvalid_i) begin
        #1;
        random_stall();
        arready_o = 1'b1;
        @(posedge clk_i);
        a = araddr_i;
        #1 arready_o = 1'b0;
        rd_addr_q.push_back(a);
        random_stall();
        rdata_o  = mem[a[13:2]];
        rvalid_o = 1'b1;
        do @(posedge clk_i); while (!rready_i);
        #1 rvalid_o = 1'b0;
      end
    end
  end

  // ------------------------------
  // write side, AW and W in any order, then B
  // ------------------------------
  initial begin
    addr_t                 a;
    word_t                 d;
    logic [`RV_XLEN/8-1:0] s;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && (awvalid_i || wvalid_i)) begin
        #1;
        fork
          begin
            random_stall();
            awready_o = 1'b1;
            @(posedge clk_i);
            a = awaddr_i;
            #1 awready_o = 1'b0;
          end
          begin
            random_stall();
            wready_o = 1'b1;
            @(posedge clk_i);
            d = wdata_i;
            s = wstrb_i;
            #1 wready_o = 1'b0;
          end
        join
        mem[a[13:2]] = d;
        wr_addr_q.push_back(a);
        wr_data_q.push_back(d);
        wr_strb_q.push_back(s);
        random_stall();
        bvalid_o = 1'b1;
        do @(posedge clk_i); while (!bready_i);
        #1 bvalid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/rv_core_tb.sv
// testbench for rv_core
// runs a random program from a fixed seed on the core and on an ISA model,
// then compares stores, fetch addresses and the retirement count

`default_nettype none

`include "rv_core_settings.svh"

module rv_core_tb import rv_core_pkg::*; ();

  localparam int    N_INSTR    = 200;
  localparam int    RST_CYCLES = 10;
  localparam int    TIMEOUT    = RST_CYCLES + N_INSTR * 40;
  localparam addr_t BOOT_ADDR  = 32'h0000_0200;
  // x31 holds this base, set by the first LUI
  localparam addr_t DATA_BASE  = 32'h0000_1000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  addr_t                 boot_addr;
  addr_t                 araddr;
  logic                  arvalid;
  logic                  arready;
  word_t                 rdata;
  logic                  rvalid;
  logic                  rready;
  addr_t                 awaddr;
  logic                  awvalid;
  logic                  awready;
  word_t                 wdata;
  logic [`RV_XLEN/8-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  logic                  bvalid;
  logic                  bready;
  count_t                instret;
  logic                  halted;

  int     seed = 1;
  int     cycles = 0;
  word_t  model_x [0:31];
  word_t  model_mem [0:4095];
  addr_t  exp_wr_addr [$];
  word_t  exp_wr_data [$];

  always #4 clk = ~clk;

  rv_core i_rv_core (
    .clk_i         ( clk       ),
    .rst_ni        ( rst_n     ),
    .boot_addr_i   ( boot_addr ),
    .axi_araddr_o  ( araddr    ),
    .axi_arvalid_o ( arvalid   ),
    .axi_arready_i ( arready   ),
    .axi_rdata_i   ( rdata     ),
    .axi_rvalid_i  ( rvalid    ),
    .axi_rready_o  ( rready    ),
    .axi_awaddr_o  ( awaddr    ),
    .axi_awvalid_o ( awvalid   ),
    .axi_awready_i ( awready   ),
    .axi_wdata_o   ( wdata     ),
    .axi_wstrb_o   ( wstrb     ),
    .axi_wvalid_o  ( wvalid    ),
    .axi_wready_i  ( wready    ),
    .axi_bvalid_i  ( bvalid    ),
    .axi_bready_o  ( bready    ),
    .instret_o     ( instret   ),
    .halted_o      ( halted    )
  );

  axi_lite_mem i_mem (
    .clk_i    ( clk     ),
    .rst_ni   ( rst_n   ),
    .araddr_i ( araddr  ),
    .arvalid_i( arvalid ),
    .arready_o( arready ),
    .rdata_o  ( rdata   ),
    .rvalid_o ( rvalid  ),
    .rready_i ( rready  ),
    .awaddr_i ( awaddr  ),
    .awvalid_i( awvalid ),
    .awready_o( awready ),
    .wdata_i  ( wdata   ),
    .wstrb_i  ( wstrb   ),
    .wvalid_i ( wvalid  ),
    .wready_o ( wready  ),
    .bvalid_o ( bvalid  ),
    .bready_i ( bready  )
  );

  // ------------------------------
  // checks
  // ------------------------------
  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // ------------------------------
  // program and ISA model
  // ------------------------------
  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // data pattern, differs in every address bit
  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  function automatic void write_reg(input reg_idx_t rd, input word_t v);
    if (rd != '0) begin
      model_x[rd] = v;
    end
  endfunction

  task automatic build_program();
    instr_t      ins;
    int          kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [11:0] off;
    addr_t       ea;
    for (int k = 0; k < 4096; k++) begin
      model_mem[k] = fill_word(addr_t'(k) << 2);
      i_mem.mem[k] = model_mem[k];
    end
    for (int r = 0; r < 32; r++) begin
      model_x[r] = '0;
    end
    for (int i = 0; i < N_INSTR; i++) begin
      // x31 never written after the base is set
      rd    = reg_idx_t'(rand_below(31));
      rs1   = reg_idx_t'(rand_below(32));
      rs2   = reg_idx_t'(rand_below(32));
      imm12 = 12'(rand_below(4096));
      imm20 = 20'($random(seed));
      off   = 12'(rand_below(16) * 4);
      ea    = DATA_BASE + addr_t'(off);
      if (i == 0) begin
        kind  = 0;
        rd    = 5'd31;
        imm20 = DATA_BASE[31:12];
      end else if (i <= 30) begin
        // give every register a known value first
        kind = 1;
        rd   = reg_idx_t'(i);
        rs1  = '0;
      end else if (i == N_INSTR - 1) begin
        kind = 9;
      end else begin
        kind = rand_below(9);
      end
      case (kind)
        0: begin
          ins = {imm20, rd, 7'b0110111};
          write_reg(rd, {imm20, 12'b0});
        end
        1: begin
          ins = {imm12, rs1, 3'b000, rd, 7'b0010011};
          write_reg(rd, model_x[rs1] + {{20{imm12[11]}}, imm12});
        end
        2: begin
          ins = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
          write_reg(rd, model_x[rs1] + model_x[rs2]);
        end
        3: begin
          ins = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
          write_reg(rd, model_x[rs1] - model_x[rs2]);
        end
        4: begin
          ins = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
          write_reg(rd, model_x[rs1] & model_x[rs2]);
        end
        5: begin
          ins = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
          write_reg(rd, model_x[rs1] | model_x[rs2]);
        end
        6: begin
          ins = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
          write_reg(rd, model_x[rs1] ^ model_x[rs2]);
        end
        7: begin
          ins = {off, 5'd31, 3'b010, rd, 7'b0000011};
          write_reg(rd, model_mem[ea[13:2]]);
        end
        8: begin
          ins = {off[11:5], rs2, 5'd31, 3'b010, off[4:0], 7'b0100011};
          model_mem[ea[13:2]] = model_x[rs2];
          exp_wr_addr.push_back(ea);
          exp_wr_data.push_back(model_x[rs2]);
        end
        default: ins = 32'h0000_0073;
      endcase
      i_mem.mem[BOOT_ADDR[13:2] + i] = ins;
    end
  endtask

  task automatic check_writes();
    check_count("write transfers", count_t'(i_mem.wr_addr_q.size()),
                count_t'(exp_wr_addr.size()));
    for (int k = 0; k < exp_wr_addr.size(); k++) begin
      check_addr("axi_awaddr_o", i_mem.wr_addr_q[k], exp_wr_addr[k]);
      check_word("axi_wdata_o", i_mem.wr_data_q[k], exp_wr_data[k]);
      check_word("axi_wstrb_o", word_t'(i_mem.wr_strb_q[k]), word_t'(4'hf));
    end
  endtask

  // fetches lie below the data region, loads above it
  task automatic check_fetches();
    addr_t rd_q [$];
    addr_t exp_pc;
    int    n;
    rd_q   = i_mem.rd_addr_q;
    exp_pc = BOOT_ADDR;
    n      = 0;
    foreach (rd_q[k]) begin
      if (rd_q[k] < DATA_BASE) begin
        check_addr("axi_araddr_o", rd_q[k], exp_pc);
        exp_pc = exp_pc + 32'd4;
        n++;
      end
    end
    if (n < N_INSTR || n > N_INSTR + 2) begin
      $display("fetched %0d words, expected %0d to %0d", n, N_INSTR, N_INSTR + 2);
      stop_with_failure();
    end
  endtask

  // ------------------------------
  // run
  // ------------------------------
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      $display("core did not halt within %0d cycles", TIMEOUT);
      stop_with_failure();
    end
  end

  initial begin
    rst_n     = 1'b0;
    boot_addr = BOOT_ADDR;
    build_program();
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    while (!halted) @(posedge clk);
    check_count("write transfers", count_t'(i_mem.wr_addr_q.size()),
                count_t'(exp_wr_addr.size()));
    // nothing more may retire or be written once halted
    repeat (20) @(posedge clk);
    check_count("instret_o", instret, count_t'(N_INSTR));
    check_writes();
    check_fetches();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/core_ifs.sv
design/fetch_unit.sv
design/exec_unit.sv
design/axi_lite_arbiter.sv
design/rv_core.sv
tb/axi_lite_mem.sv
tb/rv_core_tb.sv
